/* hw/rv_pkg.sv */
// rv32i base subset only; no loads, stores, fence or M extension, and those encodings decode illegal
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // base opcode map, load/store/fence kept only to be flagged illegal
  typedef enum logic [6:0] {
    op_lui      = 7'b0110111,
    op_auipc    = 7'b0010111,
    op_jal      = 7'b1101111,
    op_jalr     = 7'b1100111,
    op_branch   = 7'b1100011,
    op_load     = 7'b0000011,
    op_store    = 7'b0100011,
    op_misc_mem = 7'b0001111,
    op_op_imm   = 7'b0010011,
    op_op       = 7'b0110011,
    op_system   = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {
    cls_alu, cls_lui, cls_auipc, cls_branch, cls_jal, cls_jalr, cls_ecall
  } insn_class_e;

  // instruction formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_e    opcode;
  } br_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    reg_idx_t   rd;
    opcode_e    opcode;
  } j_fmt_t;

  // one fetched word, seen through each format
  typedef union packed {
    r_fmt_t  r;
    i_fmt_t  i;
    br_fmt_t b;
    u_fmt_t  u;
    j_fmt_t  j;
  } insn_u;

  typedef struct packed {
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    alu_op_e     alu_op;
    logic        b_imm;
    word_t       imm;
    insn_class_e cls;
    logic [2:0]  funct3;
    logic        we;
    logic        illegal;
  } decoded_t;

  typedef struct packed {
    word_t wdata;
    word_t next_pc;
    logic  we;
    logic  halt;
    logic  illegal;
  } exec_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    reg_idx_t rd;
    logic     we;
    word_t    wdata;
    word_t    next_pc;
  } retire_t;

endpackage

/* hw/rv_decode.sv */
// purely combinational; the only legality check in the core, illegal words never request a write
`timescale 1ns/1ps

module rv_decode (
  input  rv_pkg::insn_u    insn,
  output rv_pkg::decoded_t dec
);

  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_u;
  rv_pkg::word_t imm_j;
  rv_pkg::word_t imm_shamt;

  // alt selects sub/sra on funct7 bit 5
  function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] funct3, input logic alt);
    rv_pkg::alu_op_e op;
    case (funct3)
      3'b000: op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001: op = rv_pkg::alu_sll;
      3'b010: op = rv_pkg::alu_slt;
      3'b011: op = rv_pkg::alu_sltu;
      3'b100: op = rv_pkg::alu_xor;
      3'b101: op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110: op = rv_pkg::alu_or;
      default: op = rv_pkg::alu_and;
    endcase
    return op;
  endfunction

  assign imm_i = {{20{insn.i.imm[11]}}, insn.i.imm};
  assign imm_b = {{19{insn.b.imm12}}, insn.b.imm12, insn.b.imm11, insn.b.imm10_5,
                  insn.b.imm4_1, 1'b0};
  assign imm_u = {insn.u.imm, 12'b0};
  assign imm_j = {{11{insn.j.imm20}}, insn.j.imm20, insn.j.imm19_12, insn.j.imm11,
                  insn.j.imm10_1, 1'b0};
  assign imm_shamt = {27'b0, insn.i.imm[4:0]};

  always_comb begin
    dec.rs1 = insn.r.rs1;
    dec.rs2 = insn.r.rs2;
    dec.rd = insn.r.rd;
    dec.alu_op = rv_pkg::alu_add;
    dec.b_imm = 1'b0;
    dec.imm = imm_i;
    dec.cls = rv_pkg::cls_alu;
    dec.funct3 = insn.r.funct3;
    dec.we = 1'b0;
    dec.illegal = 1'b0;
    case (insn.r.opcode)
      rv_pkg::op_lui: begin
        dec.cls = rv_pkg::cls_lui;
        dec.alu_op = rv_pkg::alu_pass_b;
        dec.b_imm = 1'b1;
        dec.imm = imm_u;
        dec.we = 1'b1;
      end
      rv_pkg::op_auipc: begin
        dec.cls = rv_pkg::cls_auipc;
        dec.imm = imm_u;
        dec.we = 1'b1;
      end
      rv_pkg::op_jal: begin
        dec.cls = rv_pkg::cls_jal;
        dec.imm = imm_j;
        dec.we = 1'b1;
      end
      rv_pkg::op_jalr: begin
        // target comes out of the alu adder
        dec.cls = rv_pkg::cls_jalr;
        dec.b_imm = 1'b1;
        dec.we = 1'b1;
        dec.illegal = insn.r.funct3 != 3'b000;
      end
      rv_pkg::op_branch: begin
        dec.cls = rv_pkg::cls_branch;
        dec.imm = imm_b;
        dec.illegal = insn.b.funct3[2:1] == 2'b01;
      end
      rv_pkg::op_op_imm: begin
        dec.b_imm = 1'b1;
        dec.we = 1'b1;
        dec.alu_op = alu_sel(insn.r.funct3, insn.r.funct3 == 3'b101 && insn.r.funct7[5]);
        if (insn.r.funct3[1:0] == 2'b01) begin
          dec.imm = imm_shamt;
          dec.illegal = insn.r.funct7 != 7'b0000000 &&
                        !(insn.r.funct3 == 3'b101 && insn.r.funct7 == 7'b0100000);
        end
      end
      rv_pkg::op_op: begin
        dec.we = 1'b1;
        dec.alu_op = alu_sel(insn.r.funct3, insn.r.funct7[5]);
        dec.illegal = insn.r.funct7 != 7'b0000000 &&
                      !(insn.r.funct7 == 7'b0100000 &&
                        (insn.r.funct3 == 3'b000 || insn.r.funct3 == 3'b101));
      end
      rv_pkg::op_system: begin
        // only the all-zero ecall form is accepted
        dec.cls = rv_pkg::cls_ecall;
        dec.illegal = insn.i.imm != 12'd0 || insn.i.rs1 != 5'd0 ||
                      insn.i.funct3 != 3'd0 || insn.i.rd != 5'd0;
      end
      rv_pkg::op_load, rv_pkg::op_store, rv_pkg::op_misc_mem: begin
        dec.illegal = 1'b1;
      end
      default: begin
        dec.illegal = 1'b1;
      end
    endcase
    if (dec.illegal) begin
      dec.we = 1'b0;
      dec.cls = rv_pkg::cls_alu;
    end
  end

endmodule

/* hw/rv_regfile.sv */
// 31 flop registers, x0 hardwired to zero; reads are combinational, one write per clock
`timescale 1ns/1ps

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);

  rv_pkg::word_t regs [1:31];

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      // x0 writes dropped here
      regs[rd] <= rd_data;
    end
  end

endmodule

/* hw/rv_execute.sv */
// combinational alu, branch compare and next pc; trusts decode for legality and write intent
`timescale 1ns/1ps

module rv_execute (
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    pc,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  output rv_pkg::exec_t    result
);

  rv_pkg::word_t op_b;
  rv_pkg::word_t alu;
  rv_pkg::word_t pc_plus4;
  rv_pkg::word_t pc_imm;
  logic [4:0]    shamt;
  logic          taken;

  assign op_b = dec.b_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];
  assign pc_plus4 = pc + 32'd4;
  // shared by auipc, jal and taken branches
  assign pc_imm = pc + dec.imm;

  always_comb begin
    case (dec.alu_op)
      rv_pkg::alu_add: alu = rs1_data + op_b;
      rv_pkg::alu_sub: alu = rs1_data - op_b;
      rv_pkg::alu_sll: alu = rs1_data << shamt;
      rv_pkg::alu_slt: alu = {31'b0, $signed(rs1_data) < $signed(op_b)};
      rv_pkg::alu_sltu: alu = {31'b0, rs1_data < op_b};
      rv_pkg::alu_xor: alu = rs1_data ^ op_b;
      rv_pkg::alu_srl: alu = rs1_data >> shamt;
      rv_pkg::alu_sra: alu = $signed(rs1_data) >>> shamt;
      rv_pkg::alu_or: alu = rs1_data | op_b;
      rv_pkg::alu_and: alu = rs1_data & op_b;
      rv_pkg::alu_pass_b: alu = op_b;
      default: alu = '0;
    endcase
  end

  // branch condition by funct3
  always_comb begin
    case (dec.funct3)
      3'b000: taken = rs1_data == rs2_data;
      3'b001: taken = rs1_data != rs2_data;
      3'b100: taken = $signed(rs1_data) < $signed(rs2_data);
      3'b101: taken = $signed(rs1_data) >= $signed(rs2_data);
      3'b110: taken = rs1_data < rs2_data;
      3'b111: taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (dec.cls)
      rv_pkg::cls_branch: result.next_pc = taken ? pc_imm : pc_plus4;
      rv_pkg::cls_jal: result.next_pc = pc_imm;
      rv_pkg::cls_jalr: result.next_pc = {alu[31:1], 1'b0};
      default: result.next_pc = pc_plus4;
    endcase
    case (dec.cls)
      rv_pkg::cls_jal, rv_pkg::cls_jalr: result.wdata = pc_plus4;
      rv_pkg::cls_auipc: result.wdata = pc_imm;
      // lui arrives here as pass_b of the u immediate
      default: result.wdata = alu;
    endcase
    result.we = dec.we;
    result.halt = dec.cls == rv_pkg::cls_ecall || dec.illegal;
    result.illegal = dec.illegal;
  end

endmodule

/* hw/rv_retire.sv */
// reset_pc must be word aligned; halt and illegal are sticky until rst, no fetch while halted
`timescale 1ns/1ps

module rv_retire #(
  parameter rv_pkg::word_t reset_pc = 32'h0000_0000
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             insn_valid,
  input  rv_pkg::reg_idx_t dec_rd,
  input  rv_pkg::exec_t    result,
  output logic             insn_ready,
  output rv_pkg::word_t    pc,
  output logic             rf_we,
  output rv_pkg::retire_t  retire,
  output logic             halt,
  output logic             illegal
);

  logic xfer;

  assign insn_ready = !halt && !illegal;
  assign xfer = insn_valid && insn_ready;
  // regfile only sees accepted instructions
  assign rf_we = xfer && result.we;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
      halt <= 1'b0;
      illegal <= 1'b0;
      retire.valid <= 1'b0;
    end else begin
      retire.valid <= xfer;
      if (xfer) begin
        pc <= result.next_pc;
        // no transfer once halted, so these stay set
        halt <= result.halt;
        illegal <= result.illegal;
      end
    end
  end

  // retire payload, only meaningful with valid
  always_ff @(posedge clk) begin
    if (xfer) begin
      retire.pc <= pc;
      retire.rd <= dec_rd;
      retire.we <= result.we;
      retire.wdata <= result.wdata;
      retire.next_pc <= result.next_pc;
    end
  end

endmodule

/* hw/rv_core.sv */
// single-cycle rv32i subset; insn must match fetch_pc and stay stable while insn_valid waits
`timescale 1ns/1ps

module rv_core #(
  parameter rv_pkg::word_t reset_pc = 32'h0000_0000
) (
  input  logic            clk,
  input  logic            rst,
  input  rv_pkg::word_t   insn,
  input  logic            insn_valid,
  output rv_pkg::word_t   fetch_pc,
  output logic            insn_ready,
  output rv_pkg::retire_t retire,
  output logic            halt,
  output logic            illegal
);

  rv_pkg::decoded_t dec;
  rv_pkg::exec_t    result;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  logic             rf_we;

  rv_decode u_decode (
    .insn (rv_pkg::insn_u'(insn)),
    .dec  (dec)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .we       (rf_we),
    .rd       (dec.rd),
    .rd_data  (result.wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute u_execute (
    .dec      (dec),
    .pc       (fetch_pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (result)
  );

  // owns pc, so fetch_pc is the pc of the instruction being executed
  rv_retire #(
    .reset_pc (reset_pc)
  ) u_retire (
    .clk        (clk),
    .rst        (rst),
    .insn_valid (insn_valid),
    .dec_rd     (dec.rd),
    .result     (result),
    .insn_ready (insn_ready),
    .pc         (fetch_pc),
    .rf_we      (rf_we),
    .retire     (retire),
    .halt       (halt),
    .illegal    (illegal)
  );

endmodule

/* dv/rv_core_checker.sv */
// bound into rv_core; needs rst held for at least one clock before any transfer is offered
`timescale 1ns/1ps

module rv_core_checker (
  input logic            clk,
  input logic            rst,
  input logic            insn_valid,
  input logic            insn_ready,
  input logic            halt,
  input logic            illegal,
  input rv_pkg::retire_t retire
);

  // a retire record only ever follows an accepted fetch
  retire_after_xfer: assert property (@(posedge clk) disable iff (rst)
    retire.valid |-> $past(insn_valid && insn_ready))
    else $error("retire record without a transfer in the cycle before");

  xfer_then_retire: assert property (@(posedge clk) disable iff (rst)
    insn_valid && insn_ready |=> retire.valid)
    else $error("accepted instruction did not retire one cycle later");

  halt_sticky: assert property (@(posedge clk) disable iff (rst)
    halt |=> halt)
    else $error("halt dropped without a reset");

  no_fetch_while_halted: assert property (@(posedge clk) disable iff (rst)
    halt |-> !insn_ready)
    else $error("insn_ready high while halted");

  // illegal always comes with halt
  illegal_halts: assert property (@(posedge clk) disable iff (rst)
    illegal |-> halt)
    else $error("illegal set without halt");

endmodule

/* dv/rv_core_tb.sv */
// fixed-seed forward-only program; reset pc kept low so a jalr off x0 reaches every target
`timescale 1ns/1ps

module rv_core_tb;

  localparam rv_pkg::word_t start_pc = 32'h0000_0100;
  localparam int prog_len = 64;
  localparam rv_pkg::word_t ecall_word = 32'h0000_0073;

  logic            clk = 1'b0;
  logic            rst;
  rv_pkg::word_t   insn;
  logic            insn_valid;
  rv_pkg::word_t   fetch_pc;
  logic            insn_ready;
  rv_pkg::retire_t retire;
  logic            halt;
  logic            illegal;

  rv_pkg::word_t prog [0:prog_len-1];
  rv_pkg::word_t shadow [0:31];
  logic [31:0]   lcg_state;

  // expected core state, advanced by the compare process
  rv_pkg::word_t exp_pc;
  logic          exp_halt;
  logic          exp_illegal;
  logic          xfer_q = 1'b0;
  logic          run_q = 1'b0;

  rv_core #(
    .reset_pc (start_pc)
  ) UUT (
    .clk        (clk),
    .rst        (rst),
    .insn       (insn),
    .insn_valid (insn_valid),
    .fetch_pc   (fetch_pc),
    .insn_ready (insn_ready),
    .retire     (retire),
    .halt       (halt),
    .illegal    (illegal)
  );

  bind rv_core rv_core_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .insn_valid (insn_valid),
    .insn_ready (insn_ready),
    .halt       (halt),
    .illegal    (illegal),
    .retire     (retire)
  );

  always #50 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  task automatic report_mismatch(input string name, input rv_pkg::word_t got,
                                 input rv_pkg::word_t exp);
    abort_run($sformatf("[ERROR] time %0t %s got 0x%h expected 0x%h", $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) report_mismatch(name, {31'b0, got}, {31'b0, exp});
  endtask

  task automatic check_word(input string name, input rv_pkg::word_t got,
                            input rv_pkg::word_t exp);
    if (got !== exp) report_mismatch(name, got, exp);
  endtask

  // rd and wdata only carry meaning when a write is expected
  task automatic check_retire(input rv_pkg::retire_t got, input rv_pkg::retire_t exp);
    check_word("retire.pc", got.pc, exp.pc);
    check_word("retire.next_pc", got.next_pc, exp.next_pc);
    check_bit("retire.we", got.we, exp.we);
    if (exp.we) begin
      check_word("retire.rd", {27'b0, got.rd}, {27'b0, exp.rd});
      check_word("retire.wdata", got.wdata, exp.wdata);
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper bits only, the low ones cycle fast
  function automatic int unsigned rand_below(input int unsigned n);
    return (lcg_next() >> 16) % n;
  endfunction

  function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
                                          input rv_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                          input rv_pkg::reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::op_op};
  endfunction

  function automatic rv_pkg::word_t enc_i(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
                                          input logic [2:0] f3, input rv_pkg::reg_idx_t rd,
                                          input rv_pkg::opcode_e opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_pkg::word_t enc_b(input logic [12:0] off, input rv_pkg::reg_idx_t rs2,
                                          input rv_pkg::reg_idx_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::op_branch};
  endfunction

  function automatic rv_pkg::word_t enc_j(input logic [20:0] off, input rv_pkg::reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::op_jal};
  endfunction

  // all control flow jumps forward, so the closing ecall is always reached
  task automatic build_program();
    rv_pkg::reg_idx_t rd;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    logic [2:0]       f3;
    logic [4:0]       sh;
    logic             alt;
    logic [11:0]      imm;
    int unsigned      span;
    int unsigned      tgt;
    for (int k = 0; k < prog_len - 1; k++) begin
      rd = 5'(rand_below(8));
      rs1 = 5'(rand_below(8));
      rs2 = 5'(rand_below(8));
      f3 = 3'(rand_below(8));
      sh = 5'(rand_below(32));
      alt = rand_below(2) == 1;
      span = prog_len - 1 - k;
      tgt = 1 + rand_below(span < 6 ? span : 6);
      case (rand_below(10))
        0, 1, 2: begin
          if (f3 != 3'b000 && f3 != 3'b101) alt = 1'b0;
          prog[k] = enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, rd);
        end
        3, 4: begin
          if (f3 == 3'b001) imm = {7'b0, sh};
          else if (f3 == 3'b101) imm = {1'b0, alt, 5'b0, sh};
          else imm = 12'(lcg_next() >> 20);
          prog[k] = enc_i(imm, rs1, f3, rd, rv_pkg::op_op_imm);
        end
        5: prog[k] = {20'(lcg_next() >> 12), rd, alt ? rv_pkg::op_lui : rv_pkg::op_auipc};
        6, 7: begin
          // beq bne blt bge bltu bgeu
          f3 = 3'(rand_below(6));
          if (f3 >= 3'd2) f3 = f3 + 3'd2;
          prog[k] = enc_b(13'(tgt * 4), rs2, rs1, f3);
        end
        8: prog[k] = enc_j(21'(tgt * 4), rd);
        default: begin
          // odd target now and then, jalr must clear bit 0
          imm = 12'(start_pc + (k + tgt) * 4 + rand_below(2));
          prog[k] = enc_i(imm, 5'd0, 3'b000, rd, rv_pkg::op_jalr);
        end
      endcase
    end
    prog[prog_len-1] = ecall_word;
  endtask

  // addresses outside the program read as addi x0, x0, 0
  function automatic rv_pkg::word_t prog_word(input rv_pkg::word_t addr);
    rv_pkg::word_t idx;
    idx = (addr - start_pc) >> 2;
    if (idx < prog_len) return prog[idx];
    return 32'h0000_0013;
  endfunction

  function automatic logic legal_insn(input rv_pkg::word_t ins);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = ins[14:12];
    f7 = ins[31:25];
    case (ins[6:0])
      7'b0110111, 7'b0010111, 7'b1101111: return 1'b1;
      7'b1100111: return f3 == 3'b000;
      7'b1100011: return f3 != 3'b010 && f3 != 3'b011;
      7'b0010011: begin
        if (f3 == 3'b001) return f7 == 7'h00;
        if (f3 == 3'b101) return f7 == 7'h00 || f7 == 7'h20;
        return 1'b1;
      end
      7'b0110011: return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
      7'b1110011: return ins == ecall_word;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input rv_pkg::word_t a,
                                        input rv_pkg::word_t b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      3'b111: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                            input rv_pkg::word_t a, input rv_pkg::word_t b);
    rv_pkg::word_t r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else r = a >> b[4:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // one instruction against the shadow register file
  function automatic rv_pkg::retire_t ref_retire(input rv_pkg::word_t pc,
                                                 input rv_pkg::word_t ins);
    rv_pkg::retire_t r;
    rv_pkg::word_t   a;
    rv_pkg::word_t   b;
    rv_pkg::word_t   imm_i;
    rv_pkg::word_t   imm_b;
    rv_pkg::word_t   imm_u;
    rv_pkg::word_t   imm_j;
    a = shadow[ins[19:15]];
    b = shadow[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {ins[31:12], 12'b0};
    imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    r.valid = 1'b1;
    r.pc = pc;
    r.rd = ins[11:7];
    r.we = 1'b0;
    r.wdata = '0;
    r.next_pc = pc + 32'd4;
    if (legal_insn(ins)) begin
      r.we = 1'b1;
      case (ins[6:0])
        7'b0110111: r.wdata = imm_u;
        7'b0010111: r.wdata = pc + imm_u;
        7'b1101111: begin
          r.wdata = pc + 32'd4;
          r.next_pc = pc + imm_j;
        end
        7'b1100111: begin
          r.wdata = pc + 32'd4;
          r.next_pc = (a + imm_i) & ~32'd1;
        end
        7'b1100011: begin
          r.we = 1'b0;
          if (branch_taken(ins[14:12], a, b)) r.next_pc = pc + imm_b;
        end
        7'b0010011: r.wdata = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
        7'b0110011: r.wdata = alu_ref(ins[14:12], ins[30], a, b);
        default: r.we = 1'b0;
      endcase
    end
    return r;
  endfunction

  // transfer seen at the edge, judged at the next falling edge
  always @(posedge clk) begin
    xfer_q <= !rst && insn_valid && !exp_halt;
    run_q <= !rst;
  end

  always @(negedge clk) begin : compare_proc
    rv_pkg::word_t   ins;
    rv_pkg::retire_t exp_ret;
    if (run_q) begin
      check_bit("retire.valid", retire.valid, xfer_q);
      if (xfer_q) begin
        ins = prog_word(exp_pc);
        exp_ret = ref_retire(exp_pc, ins);
        check_retire(retire, exp_ret);
        if (exp_ret.we && exp_ret.rd != 5'd0) shadow[exp_ret.rd] = exp_ret.wdata;
        if (!legal_insn(ins)) exp_illegal = 1'b1;
        if (!legal_insn(ins) || ins == ecall_word) exp_halt = 1'b1;
        exp_pc = exp_ret.next_pc;
      end
      check_word("fetch_pc", fetch_pc, exp_pc);
      check_bit("halt", halt, exp_halt);
      check_bit("illegal", illegal, exp_illegal);
      check_bit("insn_ready", insn_ready, !exp_halt);
    end
  end

  // 16 reset clocks, expected state cleared while the compare process is idle
  task automatic apply_reset();
    rst = 1'b1;
    insn_valid = 1'b0;
    insn = '0;
    for (int c = 0; c < 16; c++) begin
      @(negedge clk);
      if (c == 0) begin
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        exp_pc = start_pc;
        exp_halt = 1'b0;
        exp_illegal = 1'b0;
      end
      check_bit("retire.valid", retire.valid, 1'b0);
      check_bit("halt", halt, 1'b0);
      check_bit("illegal", illegal, 1'b0);
      check_bit("insn_ready", insn_ready, 1'b1);
      check_word("fetch_pc", fetch_pc, start_pc);
    end
    rst = 1'b0;
  endtask

  initial begin : main_proc
    int cycles;
    rst = 1'b1;
    insn_valid = 1'b0;
    insn = '0;
    lcg_state = 32'd59415;
    build_program();
    apply_reset();

    // random program with random stalls up to the ecall
    cycles = 0;
    while (!halt) begin
      if (cycles == 4000) abort_run("timeout: core never halted on the closing ECALL");
      insn = prog_word(fetch_pc);
      insn_valid = rand_below(4) != 0;
      @(negedge clk);
      cycles++;
    end
    for (int c = 0; c < 20; c++) begin
      insn = prog_word(fetch_pc);
      insn_valid = 1'b1;
      @(negedge clk);
    end

    // lw x5, 8(x2) as the first word after a new reset
    prog[0] = enc_i(12'h008, 5'd2, 3'b010, 5'd5, rv_pkg::op_load);
    apply_reset();
    cycles = 0;
    while (!illegal) begin
      if (cycles == 200) abort_run("timeout: load opcode was never flagged as illegal");
      insn = prog_word(fetch_pc);
      insn_valid = 1'b1;
      @(negedge clk);
      cycles++;
    end
    for (int c = 0; c < 20; c++) begin
      insn = prog_word(fetch_pc);
      insn_valid = 1'b1;
      @(negedge clk);
    end
    @(posedge clk);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* project.f */
hw/rv_pkg.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_retire.sv
hw/rv_core.sv
dv/rv_core_checker.sv
dv/rv_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module rv_core_tb -o rv_sim

# the simulator exits nonzero on $fatal, so the log decides the result
./obj_dir/rv_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
grep -q "ALL TESTS PASSED" sim.log
